// File: src/cache_pkg.sv
/* cache geometry shared by the ways, the controller and the testbench
   address is split as tag | index | offset, a line holds four words */
package cache_pkg;

    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int WORD_W         = 32;
    localparam int NUM_SETS       = 256;
    localparam int WORDS_PER_LINE = 4;
    localparam int BANK_W         = 2;  // word select inside a line
    localparam int STRB_W         = 4;  // byte lanes per word

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [BANK_W-1:0]  bank_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [STRB_W-1:0]  strb_t;

    // one cache line
    // banks are addressed one word at a time, the bus moves the whole block
    typedef union packed {
        word_t [WORDS_PER_LINE-1:0]        words;  // indexed by bank
        logic [WORDS_PER_LINE*WORD_W-1:0] block;  // flat writeback view
    } line_t;

endpackage

// File: src/ctrl_pkg.sv
/* request codes and controller states, shared with the testbench */
package ctrl_pkg;

    // cpu request op
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    typedef enum logic [2:0] {
        IDLE,      // waiting for a request
        LOOKUP,    // tag compare, read hit answers here
        WRITEHIT,  // commit of a write hit
        MISS,      // dirty victim writeback
        REPLACE,   // line read request to memory
        REFILL     // four returned words go into the victim way
    } state_t;

endpackage

// File: src/data_bank_ram.sv
`timescale 1ns/1ps
/* single-port synchronous RAM, one entry per set, byte-lane writes
   widths that are not a byte multiple get a single write lane */
module data_bank_ram #(
    parameter int  WIDTH  = 32,
    localparam int LANES  = (WIDTH % 8 == 0) ? WIDTH / 8 : 1,
    localparam int LANE_W = WIDTH / LANES
) (
    input  logic              clk,
    input  logic              en,
    input  logic [LANES-1:0]  we,
    input  cache_pkg::index_t addr,
    input  logic [WIDTH-1:0]  din,
    output logic [WIDTH-1:0]  dout
);
    import cache_pkg::*;

    logic [WIDTH-1:0] mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < LANES; i++) begin
                if (we[i]) mem[addr][i*LANE_W +: LANE_W] <= din[i*LANE_W +: LANE_W];
            end
            dout <= mem[addr];  // read-first, holds while en is low
        end
    end

endmodule

// File: src/cache_way.sv
`timescale 1ns/1ps
/* one cache way: tag RAM, four word banks, valid/dirty flops and tag compare
   status refers to the set read by the last rd_en */
module cache_way (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_en,
    input  cache_pkg::index_t rd_index,
    input  cache_pkg::tag_t   cmp_tag,
    input  logic              wr_en,
    input  cache_pkg::index_t wr_index,
    input  cache_pkg::bank_t  wr_bank,
    input  cache_pkg::strb_t  wr_strb,
    input  cache_pkg::word_t  wr_word,
    input  logic              tag_wr,
    input  logic              set_dirty,
    input  logic              clr_dirty,
    output logic              hit,
    output logic              line_valid,
    output logic              line_dirty,
    output cache_pkg::tag_t   stored_tag,
    output cache_pkg::line_t  line
);
    import cache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    index_t              rd_index_q;
    index_t              ram_index;
    word_t               bank_dout [WORDS_PER_LINE];

    // reads only happen in IDLE, writes never do
    assign ram_index = rd_en ? rd_index : wr_index;

    data_bank_ram #(.WIDTH(TAG_W)) u_tag_ram (
        .clk  (clk),
        .en   (rd_en | tag_wr),
        .we   (tag_wr),
        .addr (ram_index),
        .din  (cmp_tag),
        .dout (stored_tag)
    );

    for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
        logic bank_wr;

        assign bank_wr = wr_en && (wr_bank == bank_t'(b));

        // unwritten banks keep their output for the writeback
        data_bank_ram #(.WIDTH(WORD_W)) u_bank (
            .clk  (clk),
            .en   (rd_en | bank_wr),
            .we   (bank_wr ? wr_strb : {STRB_W{1'b0}}),
            .addr (ram_index),
            .din  (wr_word),
            .dout (bank_dout[b])
        );
    end

    always_comb begin
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line.words[i] = bank_dout[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_index_q <= '0;
        end else begin
            if (rd_en) rd_index_q <= rd_index;
            if (tag_wr) valid_q[wr_index] <= 1'b1;  // new line installed
            if (set_dirty) dirty_q[wr_index] <= 1'b1;
            else if (clr_dirty) dirty_q[wr_index] <= 1'b0;
        end
    end

    assign line_valid = valid_q[rd_index_q];
    assign line_dirty = dirty_q[rd_index_q];
    assign hit        = line_valid && (stored_tag == cmp_tag);

endmodule

// File: src/cache_ctrl.sv
`timescale 1ns/1ps
/* cache controller: request buffer, main FSM, LRU and victim choice
   drives both ways and the memory side read and writeback requests */
module cache_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    // cpu side
    input  logic                           valid,
    input  logic                           op,
    input  cache_pkg::index_t              index,
    input  cache_pkg::tag_t                tag,
    input  logic [cache_pkg::OFFSET_W-1:0] offset,
    input  cache_pkg::strb_t               wstrb,
    input  cache_pkg::word_t               wdata,
    output logic                           addr_ok,
    output logic                           data_ok,
    output cache_pkg::word_t               rdata,
    // memory side
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  cache_pkg::word_t               ret_data,
    input  logic                           wr_rdy,
    output logic                           rd_req,
    output logic [31:0]                    rd_addr,
    output logic                           wr_req,
    output logic [31:0]                    wr_addr,
    output cache_pkg::line_t               wr_data,
    // way status
    input  logic                           hit_w0,
    input  logic                           line_valid_w0,
    input  logic                           line_dirty_w0,
    input  cache_pkg::tag_t                stored_tag_w0,
    input  cache_pkg::line_t               line_w0,
    input  logic                           hit_w1,
    input  logic                           line_valid_w1,
    input  logic                           line_dirty_w1,
    input  cache_pkg::tag_t                stored_tag_w1,
    input  cache_pkg::line_t               line_w1,
    // way controls
    output logic                           rd_en_w0,
    output logic                           wr_en_w0,
    output logic                           tag_wr_w0,
    output logic                           set_dirty_w0,
    output logic                           clr_dirty_w0,
    output logic                           rd_en_w1,
    output logic                           wr_en_w1,
    output logic                           tag_wr_w1,
    output logic                           set_dirty_w1,
    output logic                           clr_dirty_w1,
    output cache_pkg::index_t              rd_index,
    output cache_pkg::tag_t                cmp_tag,
    output cache_pkg::index_t              wr_index,
    output cache_pkg::bank_t               wr_bank,
    output cache_pkg::strb_t               wr_strb,
    output cache_pkg::word_t               wr_word
);
    import cache_pkg::*;
    import ctrl_pkg::*;

    state_t              state;
    state_t              next_state;
    logic                req_op;      // request buffer
    index_t              req_index;
    tag_t                req_tag;
    bank_t               req_bank;
    strb_t               req_wstrb;
    word_t               req_wdata;
    bank_t               refill_cnt;  // bank of the next returned word
    logic                hit_way;
    logic                victim_way;
    logic [NUM_SETS-1:0] lru;         // 1 means way1 is the victim
    logic                accept;
    logic                hit_any;
    logic                victim_pick;
    logic                victim_dirty;
    logic                refill_beat;
    logic                refill_target;
    word_t               merged_word;

    assign accept        = (state == IDLE) && valid;
    assign hit_any       = hit_w0 | hit_w1;
    assign refill_beat   = (state == REFILL) && ret_valid;
    assign refill_target = refill_beat && (refill_cnt == req_bank);

    // invalid way first, otherwise the LRU way
    assign victim_pick  = !line_valid_w0 ? 1'b0 : !line_valid_w1 ? 1'b1 : lru[req_index];
    assign victim_dirty = victim_way ? (line_valid_w1 && line_dirty_w1)
                                     : (line_valid_w0 && line_dirty_w0);

    always_ff @(posedge clk) begin
        if (reset) state <= IDLE;
        else state <= next_state;
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE:     if (valid) next_state = LOOKUP;
            LOOKUP: begin
                if (!hit_any) next_state = MISS;
                else if (req_op == OP_WRITE) next_state = WRITEHIT;
                else next_state = IDLE;
            end
            WRITEHIT: next_state = IDLE;
            MISS:     if (!victim_dirty || wr_rdy) next_state = REPLACE;
            REPLACE:  if (rd_rdy) next_state = REFILL;
            REFILL:   if (ret_valid && ret_last) next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= offset[OFFSET_W-1 -: BANK_W];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_cnt <= '0;
            hit_way    <= 1'b0;
            victim_way <= 1'b0;
        end else begin
            if (refill_beat) refill_cnt <= refill_cnt + bank_t'(1);  // wraps after 4
            if (state == LOOKUP) begin
                if (hit_any) hit_way <= hit_w1;
                else victim_way <= victim_pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (state == LOOKUP && hit_any) begin
            lru[req_index] <= hit_w0;  // the other way becomes LRU
        end else if (refill_beat && ret_last) begin
            lru[req_index] <= ~victim_way;
        end
    end

    // write miss data over the returned word
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            merged_word[8*i +: 8] = req_wstrb[i] ? req_wdata[8*i +: 8] : ret_data[8*i +: 8];
        end
    end

    assign addr_ok = (state == IDLE);
    assign data_ok = (state == LOOKUP && hit_any && req_op == OP_READ)
                   || (state == WRITEHIT) || refill_target;
    assign rdata   = (state == REFILL) ? ret_data
                   : hit_w1 ? line_w1.words[req_bank] : line_w0.words[req_bank];

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};
    assign wr_req  = (state == MISS) && victim_dirty;
    assign wr_addr = {victim_way ? stored_tag_w1 : stored_tag_w0, req_index, {OFFSET_W{1'b0}}};
    assign wr_data.block = victim_way ? line_w1.block : line_w0.block;

    assign rd_en_w0 = accept;
    assign rd_en_w1 = accept;
    assign rd_index = index;
    assign cmp_tag  = req_tag;
    assign wr_index = req_index;
    assign wr_bank  = (state == REFILL) ? refill_cnt : req_bank;
    assign wr_strb  = (state == REFILL) ? {STRB_W{1'b1}} : req_wstrb;
    assign wr_word  = (state != REFILL) ? req_wdata
                    : (refill_cnt == req_bank && req_op == OP_WRITE) ? merged_word : ret_data;

    assign wr_en_w0  = (state == WRITEHIT && !hit_way) || (refill_beat && !victim_way);
    assign wr_en_w1  = (state == WRITEHIT && hit_way) || (refill_beat && victim_way);
    assign tag_wr_w0 = refill_target && !victim_way;  // tag goes in with the requested word
    assign tag_wr_w1 = refill_target && victim_way;

    assign set_dirty_w0 = (state == WRITEHIT && !hit_way) || (tag_wr_w0 && req_op == OP_WRITE);
    assign set_dirty_w1 = (state == WRITEHIT && hit_way) || (tag_wr_w1 && req_op == OP_WRITE);
    assign clr_dirty_w0 = tag_wr_w0 && req_op == OP_READ;
    assign clr_dirty_w1 = tag_wr_w1 && req_op == OP_READ;

endmodule

// File: src/cache_top.sv
`timescale 1ns/1ps
/* 2-way write-back cache top: two ways side by side under one controller */
module cache_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           valid,
    input  logic                           op,
    input  cache_pkg::index_t              index,
    input  cache_pkg::tag_t                tag,
    input  logic [cache_pkg::OFFSET_W-1:0] offset,
    input  cache_pkg::strb_t               wstrb,
    input  cache_pkg::word_t               wdata,
    output logic                           addr_ok,
    output logic                           data_ok,
    output cache_pkg::word_t               rdata,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  cache_pkg::word_t               ret_data,
    input  logic                           wr_rdy,
    output logic                           rd_req,
    output logic [31:0]                    rd_addr,
    output logic                           wr_req,
    output logic [31:0]                    wr_addr,
    output cache_pkg::line_t               wr_data
);
    import cache_pkg::*;

    logic   hit_w0, line_valid_w0, line_dirty_w0;
    logic   hit_w1, line_valid_w1, line_dirty_w1;
    tag_t   stored_tag_w0, stored_tag_w1;
    line_t  line_w0, line_w1;
    logic   rd_en_w0, wr_en_w0, tag_wr_w0, set_dirty_w0, clr_dirty_w0;
    logic   rd_en_w1, wr_en_w1, tag_wr_w1, set_dirty_w1, clr_dirty_w1;
    index_t rd_index, wr_index;  // shared by both ways
    tag_t   cmp_tag;
    bank_t  wr_bank;
    strb_t  wr_strb;
    word_t  wr_word;

    cache_way u_way0 (
        .clk (clk), .reset (reset),
        .rd_en (rd_en_w0), .rd_index (rd_index), .cmp_tag (cmp_tag),
        .wr_en (wr_en_w0), .wr_index (wr_index), .wr_bank (wr_bank),
        .wr_strb (wr_strb), .wr_word (wr_word), .tag_wr (tag_wr_w0),
        .set_dirty (set_dirty_w0), .clr_dirty (clr_dirty_w0),
        .hit (hit_w0), .line_valid (line_valid_w0), .line_dirty (line_dirty_w0),
        .stored_tag (stored_tag_w0), .line (line_w0)
    );

    cache_way u_way1 (
        .clk (clk), .reset (reset),
        .rd_en (rd_en_w1), .rd_index (rd_index), .cmp_tag (cmp_tag),
        .wr_en (wr_en_w1), .wr_index (wr_index), .wr_bank (wr_bank),
        .wr_strb (wr_strb), .wr_word (wr_word), .tag_wr (tag_wr_w1),
        .set_dirty (set_dirty_w1), .clr_dirty (clr_dirty_w1),
        .hit (hit_w1), .line_valid (line_valid_w1), .line_dirty (line_dirty_w1),
        .stored_tag (stored_tag_w1), .line (line_w1)
    );

    // port and wire names match the controller one to one
    cache_ctrl u_ctrl (.*);

endmodule

// File: tests/cache_checker.sv
`timescale 1ns/1ps
/* protocol assertions on the controller strobes, bound into cache_ctrl */
module cache_checker (
    input logic             clk,
    input logic             reset,
    input logic             addr_ok,
    input logic             data_ok,
    input logic             rd_req,
    input logic             rd_rdy,
    input logic             wr_req,
    input ctrl_pkg::state_t state
);
    import ctrl_pkg::*;

    int failures = 0;

    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> addr_ok && !data_ok && !rd_req && !wr_req)
        else begin
            $error("controller outputs are wrong right after reset");
            failures++;
        end

    a_ok_exclusive: assert property (@(posedge clk) disable iff (reset) !(addr_ok && data_ok))
        else begin
            $error("addr_ok and data_ok are high in the same cycle");
            failures++;
        end

    // line read request must wait for the memory
    a_rd_hold: assert property (@(posedge clk) disable iff (reset) rd_req && !rd_rdy |=> rd_req)
        else begin
            $error("rd_req dropped before rd_rdy");
            failures++;
        end

    a_wr_in_miss: assert property (@(posedge clk) disable iff (reset) wr_req |-> state == MISS)
        else begin
            $error("wr_req raised outside the MISS state");
            failures++;
        end

    a_no_data_idle: assert property (@(posedge clk) disable iff (reset) data_ok |-> state != IDLE)
        else begin
            $error("data_ok pulsed while the controller is idle");
            failures++;
        end

endmodule

// File: tests/cache_monitor.sv
`timescale 1ns/1ps
/* watches the cache ports and keeps a golden word memory
   compares read data, writeback lines, hit, writeback flag and hit latency */
module cache_monitor #(
    parameter logic [31:0] FILL_KEY = 32'h0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           valid,
    input  logic                           addr_ok,
    input  logic                           op,
    input  cache_pkg::index_t              index,
    input  cache_pkg::tag_t                tag,
    input  logic [cache_pkg::OFFSET_W-1:0] offset,
    input  cache_pkg::strb_t               wstrb,
    input  cache_pkg::word_t               wdata,
    input  logic                           data_ok,
    input  cache_pkg::word_t               rdata,
    input  logic                           rd_req,
    input  logic                           wr_req,
    input  logic                           wr_rdy,
    input  logic [31:0]                    wr_addr,
    input  cache_pkg::line_t               wr_data,
    input  bit                             exp_hit,
    input  bit                             exp_wb,
    output int                             errors
);
    import cache_pkg::*;
    import ctrl_pkg::*;

    word_t       golden [logic [31:0]];  // only words written so far
    logic        req_op;
    logic [31:0] req_addr;
    int          cycles;
    bit          saw_rd;
    bit          saw_wr;

    initial errors = 0;

    function automatic word_t golden_word(logic [31:0] addr);
        return golden.exists(addr) ? golden[addr] : addr ^ FILL_KEY;
    endfunction

    task automatic report(string what, logic [127:0] expected, logic [127:0] actual);
        errors++;
        $display("FAIL %s: %s expected %0h, actual %0h", cache_tb.test_name, what,
                 expected, actual);
    endtask

    always @(posedge clk) begin : watch
        word_t        merged;
        logic [127:0] exp_line;
        if (!reset && valid && addr_ok) begin
            req_op   = op;
            req_addr = {tag, index, offset[OFFSET_W-1:2], 2'b00};
            cycles   = 0;
            saw_rd   = 1'b0;
            saw_wr   = 1'b0;
            if (op == OP_WRITE) begin
                merged = golden_word(req_addr);
                for (int i = 0; i < STRB_W; i++) begin
                    if (wstrb[i]) merged[8*i +: 8] = wdata[8*i +: 8];
                end
                golden[req_addr] = merged;
            end
        end else if (!reset) begin
            cycles++;
            saw_rd |= rd_req;
            saw_wr |= wr_req;
        end
        if (!reset && wr_req && wr_rdy) begin  // block transfer on this edge
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                exp_line[32*i +: 32] = golden_word(wr_addr + 32'(4 * i));
            end
            if (wr_data.block !== exp_line) report("writeback line", exp_line, wr_data.block);
        end
        if (!reset && data_ok) begin
            if (req_op == OP_READ && rdata !== golden_word(req_addr)) begin
                report("rdata", golden_word(req_addr), rdata);
            end
            if (saw_rd == exp_hit) report("hit", exp_hit, !saw_rd);  // hits never read memory
            if (saw_wr != exp_wb) report("writeback flag", exp_wb, saw_wr);
            if (exp_hit && cycles != (req_op == OP_WRITE ? 2 : 1)) begin
                report("hit latency", (req_op == OP_WRITE ? 2 : 1), cycles);
            end
        end
    end

endmodule

// File: tests/cache_tb.sv
`timescale 1ns/1ps
/* 2-way cache testbench with clock, reset, memory model and request table
   cache_monitor and the bound cache_checker do the comparing */
module cache_tb;
    import cache_pkg::*;
    import ctrl_pkg::*;

    localparam logic [31:0] FILL_KEY       = 32'h5a3c_96e1;  // unwritten word = address ^ key
    localparam int          CYCLES_PER_REQ = 40;
    localparam int          RESET_CYCLES   = 5;

    logic                clk, reset, valid, op, addr_ok, data_ok;
    index_t              index;
    tag_t                tag;
    logic [OFFSET_W-1:0] offset;
    strb_t               wstrb;
    word_t               wdata, rdata, ret_data;
    logic                rd_rdy, ret_valid, ret_last, wr_rdy, rd_req, wr_req;
    logic [31:0]         rd_addr, wr_addr;
    line_t               wr_data;
    logic [127:0]        mem_lines [logic [31:0]];  // written-back lines
    string               test_name;
    bit                  exp_hit, exp_wb;
    int                  mon_errors;

    // request table columns
    string       t_name [$];
    logic        t_op [$];
    logic [31:0] t_addr [$];
    strb_t       t_wstrb [$];
    word_t       t_wdata [$];
    bit          t_hit [$];
    bit          t_wb [$];

    cache_top u_cache_top (.*);
    cache_monitor #(.FILL_KEY(FILL_KEY)) u_monitor (.errors(mon_errors), .*);
    bind cache_ctrl cache_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t mem_word(logic [31:0] line_addr, int bank);
        if (mem_lines.exists(line_addr)) return mem_lines[line_addr][32*bank +: 32];
        return (line_addr + 32'(4 * bank)) ^ FILL_KEY;
    endfunction

    always @(posedge clk) begin : write_port
        logic in_reset;
        if (wr_req && wr_rdy) mem_lines[wr_addr] = wr_data.block;
        in_reset = reset;
        #1 wr_rdy = in_reset ? 1'b0 : ~wr_rdy;  // ready on alternate cycles
    end

    // rd_rdy one cycle after rd_req, then four words with a gap after the second
    always @(posedge clk) begin : read_port
        logic [31:0] line_addr;
        if (rd_req === 1'b1) begin
            line_addr = rd_addr;
            #1 rd_rdy = 1'b1;
            @(posedge clk);
            #1 rd_rdy = 1'b0;
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                if (b == 2) begin
                    ret_valid = 1'b0;
                    @(posedge clk);
                    #1;
                end
                ret_valid = 1'b1;
                ret_last  = (b == WORDS_PER_LINE - 1);
                ret_data  = mem_word(line_addr, b);
                @(posedge clk);
                #1;
            end
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    end

    task automatic add_entry(string name, logic rw, logic [31:0] addr, strb_t strb,
                             word_t data, bit hit, bit wb);
        t_name.push_back(name);
        t_op.push_back(rw);
        t_addr.push_back(addr);
        t_wstrb.push_back(strb);
        t_wdata.push_back(data);
        t_hit.push_back(hit);
        t_wb.push_back(wb);
    endtask

    // drives one request and returns 1 ns after its data_ok edge
    task automatic run_request(int i);
        test_name = t_name[i];
        exp_hit   = t_hit[i];
        exp_wb    = t_wb[i];
        valid     = 1'b1;
        op        = t_op[i];
        wstrb     = t_wstrb[i];
        wdata     = t_wdata[i];
        {tag, index, offset} = t_addr[i];
        do @(posedge clk); while (addr_ok !== 1'b1);
        #1 valid = 1'b0;
        do @(posedge clk); while (data_ok !== 1'b1);
        #1;
    endtask

    initial begin
        {valid, op, index, tag, offset, wstrb, wdata} = '0;
        {rd_rdy, ret_valid, ret_last, ret_data, wr_rdy} = '0;
        reset = 1'b1;
        // set 0x10 holds tags 1 to 3, set 0x20 tags 4 to 7
        add_entry("rd_miss_a",  OP_READ,  32'h0000_1104, 4'h0, 32'h0,         0, 0);
        add_entry("rd_hit_a",   OP_READ,  32'h0000_1104, 4'h0, 32'h0,         1, 0);
        add_entry("wr_hit_a",   OP_WRITE, 32'h0000_1108, 4'h6, 32'hdead_beef, 1, 0);
        add_entry("rd_merge_a", OP_READ,  32'h0000_1108, 4'h0, 32'h0,         1, 0);
        add_entry("rd_miss_b",  OP_READ,  32'h0000_2100, 4'h0, 32'h0,         0, 0);
        add_entry("rd_hit_a2",  OP_READ,  32'h0000_110c, 4'h0, 32'h0,         1, 0);
        add_entry("rd_miss_c",  OP_READ,  32'h0000_3100, 4'h0, 32'h0,         0, 0);  // b is lru
        add_entry("rd_hit_a3",  OP_READ,  32'h0000_1104, 4'h0, 32'h0,         1, 0);
        add_entry("rd_miss_b2", OP_READ,  32'h0000_2104, 4'h0, 32'h0,         0, 0);
        add_entry("rd_miss_c2", OP_READ,  32'h0000_3108, 4'h0, 32'h0,         0, 1);  // dirty a out
        add_entry("rd_back_a",  OP_READ,  32'h0000_1108, 4'h0, 32'h0,         0, 0);
        add_entry("wr_miss_d",  OP_WRITE, 32'h0000_4204, 4'h9, 32'h1122_3344, 0, 0);
        add_entry("rd_word_d",  OP_READ,  32'h0000_4204, 4'h0, 32'h0,         1, 0);
        add_entry("rd_next_d",  OP_READ,  32'h0000_420c, 4'h0, 32'h0,         1, 0);
        add_entry("wr_miss_e",  OP_WRITE, 32'h0000_5200, 4'hf, 32'hcafe_f00d, 0, 0);
        add_entry("rd_miss_f",  OP_READ,  32'h0000_6200, 4'h0, 32'h0,         0, 1);
        add_entry("wr_miss_g",  OP_WRITE, 32'h0000_7208, 4'h3, 32'h0000_abcd, 0, 1);
        add_entry("rd_back_d",  OP_READ,  32'h0000_4204, 4'h0, 32'h0,         0, 0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < t_name.size(); i++) begin
            run_request(i);
        end
        do @(posedge clk); while (addr_ok !== 1'b1);  // let the last refill finish
        $display("closing: %0d check errors, %0d assertion failures", mon_errors,
                 u_cache_top.u_ctrl.u_checker.failures);
        if (mon_errors == 0 && u_cache_top.u_ctrl.u_checker.failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #1;
        repeat (RESET_CYCLES + CYCLES_PER_REQ * t_name.size()) @(posedge clk);
        $display("timeout: the cache did not finish the request table in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: flist.f
src/cache_pkg.sv
src/ctrl_pkg.sv
src/data_bank_ram.sv
src/cache_way.sv
src/cache_ctrl.sv
src/cache_top.sv
tests/cache_checker.sv
tests/cache_monitor.sv
tests/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - src/cache_pkg.sv
  - src/ctrl_pkg.sv
  - src/data_bank_ram.sv
  - src/cache_way.sv
  - src/cache_ctrl.sv
  - src/cache_top.sv
  - target: test
    files:
      - tests/cache_checker.sv
      - tests/cache_monitor.sv
      - tests/cache_tb.sv
